//--- exec_pkg.sv
package exec_pkg;

	localparam int xlen = 32;
	localparam int op_count = 37;

	// register ops
	localparam int op_add = 0;
	localparam int op_sub = 1;
	localparam int op_xor = 2;
	localparam int op_or = 3;
	localparam int op_and = 4;
	localparam int op_sll = 5;
	localparam int op_srl = 6;
	localparam int op_sra = 7;
	localparam int op_slt = 8;
	localparam int op_sltu = 9;
	// immediate ops
	localparam int op_addi = 10;
	localparam int op_xori = 11;
	localparam int op_ori = 12;
	localparam int op_andi = 13;
	localparam int op_slli = 14;
	localparam int op_srli = 15;
	localparam int op_srai = 16;
	localparam int op_slti = 17;
	localparam int op_sltiu = 18;
	// loads and stores
	localparam int op_lb = 19;
	localparam int op_lh = 20;
	localparam int op_lw = 21;
	localparam int op_lbu = 22;
	localparam int op_lhu = 23;
	localparam int op_sb = 24;
	localparam int op_sh = 25;
	localparam int op_sw = 26;
	// branches and jumps
	localparam int op_beq = 27;
	localparam int op_bne = 28;
	localparam int op_blt = 29;
	localparam int op_bge = 30;
	localparam int op_bltu = 31;
	localparam int op_bgeu = 32;
	localparam int op_jal = 33;
	localparam int op_jalr = 34;
	localparam int op_lui = 35;
	localparam int op_auipc = 36;

	typedef logic [op_count-1:0] op_word_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and
	} alu_op_e;

	typedef enum logic [2:0] {
		cls_alu, cls_load, cls_store, cls_branch,
		cls_jal, cls_jalr, cls_lui, cls_auipc
	} op_class_e;

	// bit 2 set means zero extension
	typedef enum logic [2:0] {
		mem_byte = 3'b000,
		mem_half = 3'b001,
		mem_word = 3'b010,
		mem_byte_u = 3'b100,
		mem_half_u = 3'b101,
		mem_word_u = 3'b110
	} mem_kind_e;

	typedef union packed {
		logic [xlen-1:0] value; // sign-extended i/s/b/j form
		struct packed {
			logic [19:0] upper;
			logic [11:0] zero;
		} u_form;
	} imm_u;

	typedef struct packed {
		op_word_t op;
		logic [xlen-1:0] rs1;
		logic [xlen-1:0] rs2;
		imm_u imm;
		logic [xlen-1:0] pc;
	} issue_t;

	typedef struct packed {
		logic [xlen-1:0] rd_value;
		logic rd_we;
		logic jump;
		logic [xlen-1:0] jump_target;
	} result_t;

	typedef struct packed {
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wdata;
		logic we;
	} mem_req_t;

endpackage

//--- op_decode.sv
`timescale 1ns/1ps
module op_decode import exec_pkg::*; (
	input op_word_t op,
	output op_class_e op_class,
	output alu_op_e alu_op,
	output logic use_imm,
	output mem_kind_e mem_kind
);

	// imm ops plus every load and store take the immediate as operand b
	assign use_imm = (|op[op_sltiu:op_addi]) | (|op[op_sw:op_lb]);

	always_comb begin
		case (1'b1)
			|op[op_lhu:op_lb]: op_class = cls_load;
			|op[op_sw:op_sb]: op_class = cls_store;
			|op[op_bgeu:op_beq]: op_class = cls_branch;
			op[op_jal]: op_class = cls_jal;
			op[op_jalr]: op_class = cls_jalr;
			op[op_lui]: op_class = cls_lui;
			op[op_auipc]: op_class = cls_auipc;
			default: op_class = cls_alu;
		endcase
	end

	always_comb begin
		case (1'b1)
			op[op_sub]: alu_op = alu_sub;
			op[op_xor], op[op_xori]: alu_op = alu_xor;
			op[op_or], op[op_ori]: alu_op = alu_or;
			op[op_and], op[op_andi]: alu_op = alu_and;
			op[op_sll], op[op_slli]: alu_op = alu_sll;
			op[op_srl], op[op_srli]: alu_op = alu_srl;
			op[op_sra], op[op_srai]: alu_op = alu_sra;
			op[op_slt], op[op_slti]: alu_op = alu_slt;
			op[op_sltu], op[op_sltiu]: alu_op = alu_sltu;
			default: alu_op = alu_add; // add, addi and address calc
		endcase
	end

	always_comb begin
		case (1'b1)
			op[op_lb], op[op_sb]: mem_kind = mem_byte;
			op[op_lh], op[op_sh]: mem_kind = mem_half;
			op[op_lbu]: mem_kind = mem_byte_u;
			op[op_lhu]: mem_kind = mem_half_u;
			default: mem_kind = mem_word;
		endcase
	end

endmodule

//--- alu.sv
`timescale 1ns/1ps
module alu import exec_pkg::*; (
	input alu_op_e alu_op,
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] b,
	output logic [xlen-1:0] y
);

	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;

	assign shamt = b[4:0]; // only low five bits count
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	always_comb begin
		case (alu_op)
			alu_add: y = a + b;
			alu_sub: y = a - b;
			alu_sll: y = a << shamt;
			alu_slt: y = {{(xlen-1){1'b0}}, lt_s};
			alu_sltu: y = {{(xlen-1){1'b0}}, lt_u};
			alu_xor: y = a ^ b;
			alu_srl: y = a >> shamt;
			alu_sra: y = $signed(a) >>> shamt;
			alu_or: y = a | b;
			alu_and: y = a & b;
			default: y = '0;
		endcase
	end

endmodule

//--- branch_unit.sv
`timescale 1ns/1ps
module branch_unit import exec_pkg::*; (
	input op_word_t op,
	input logic [xlen-1:0] rs1,
	input logic [xlen-1:0] rs2,
	input logic [xlen-1:0] pc,
	input imm_u imm,
	output logic taken,
	output logic [xlen-1:0] target,
	output logic [xlen-1:0] link
);

	logic eq;
	logic lt_s;
	logic lt_u;
	logic [xlen-1:0] jalr_sum;

	assign eq = rs1 == rs2;
	assign lt_s = $signed(rs1) < $signed(rs2);
	assign lt_u = rs1 < rs2;

	always_comb begin
		case (1'b1)
			op[op_beq]: taken = eq;
			op[op_bne]: taken = !eq;
			op[op_blt]: taken = lt_s;
			op[op_bge]: taken = !lt_s;
			op[op_bltu]: taken = lt_u;
			op[op_bgeu]: taken = !lt_u;
			op[op_jal], op[op_jalr]: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign jalr_sum = rs1 + imm.value;
	assign target = op[op_jalr] ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm.value; // jalr drops bit 0
	assign link = pc + xlen'(4);

endmodule

//--- lsu.sv
`timescale 1ns/1ps
module lsu import exec_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	input mem_kind_e kind,
	input logic is_store,
	input logic [xlen-1:0] addr,
	input logic [xlen-1:0] store_data,
	output logic mem_req_valid,
	output mem_req_t mem_req,
	input logic mem_req_ready,
	input logic mem_rsp_valid,
	input logic [xlen-1:0] mem_rdata,
	output logic done,
	output logic [xlen-1:0] load_value
);

	typedef enum logic [1:0] {s_idle, s_req, s_rsp, s_wr} state_e;

	state_e state;
	mem_kind_e kind_q;
	logic store_q;
	logic [1:0] off_q;
	logic direct_write;
	logic [7:0] lane_b;
	logic [15:0] lane_h;
	logic [xlen-1:0] merged;

	assign direct_write = is_store && (kind == mem_word || kind == mem_word_u); // sw skips the read
	assign mem_req_valid = (state == s_req) || (state == s_wr);

	assign lane_b = mem_rdata[{off_q, 3'b000} +: 8];
	assign lane_h = mem_rdata[{off_q[1], 4'b0000} +: 16];

	always_comb begin
		case (kind_q)
			mem_byte: load_value = {{24{lane_b[7]}}, lane_b};
			mem_byte_u: load_value = {24'b0, lane_b};
			mem_half: load_value = {{16{lane_h[15]}}, lane_h};
			mem_half_u: load_value = {16'b0, lane_h};
			default: load_value = mem_rdata;
		endcase
	end

	// new lane dropped into the word just read
	always_comb begin
		merged = mem_rdata;
		case (kind_q)
			mem_byte, mem_byte_u: merged[{off_q, 3'b000} +: 8] = mem_req.wdata[7:0];
			mem_half, mem_half_u: merged[{off_q[1], 4'b0000} +: 16] = mem_req.wdata[15:0];
			default: merged = mem_req.wdata;
		endcase
	end

	always_comb begin
		case (state)
			s_req: done = mem_req_ready && mem_req.we;
			s_rsp: done = mem_rsp_valid && !store_q;
			s_wr: done = mem_req_ready;
			default: done = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s_idle;
		end else begin
			case (state)
				s_idle: if (start) state <= s_req;
				s_req: if (mem_req_ready) state <= mem_req.we ? s_idle : s_rsp;
				s_rsp: if (mem_rsp_valid) state <= store_q ? s_wr : s_idle;
				s_wr: if (mem_req_ready) state <= s_idle;
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_idle && start) begin
			mem_req.addr <= {addr[xlen-1:2], 2'b00}; // word aligned
			mem_req.wdata <= store_data;
			mem_req.we <= direct_write;
			kind_q <= kind;
			store_q <= is_store;
			off_q <= addr[1:0];
		end else if (state == s_rsp && mem_rsp_valid && store_q) begin
			mem_req.wdata <= merged; // turn into the write half
			mem_req.we <= 1'b1;
		end
	end

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps
module exec_unit import exec_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input issue_t in,
	output logic out_valid,
	input logic out_ready,
	output result_t out,
	output logic mem_req_valid,
	output mem_req_t mem_req,
	input logic mem_req_ready,
	input logic mem_rsp_valid,
	input logic [xlen-1:0] mem_rdata
);

	issue_t iss_q;
	logic busy;
	logic exec_cycle;
	op_class_e op_class;
	alu_op_e alu_op;
	logic use_imm;
	mem_kind_e mem_kind;
	logic [xlen-1:0] alu_y;
	logic taken;
	logic [xlen-1:0] target;
	logic [xlen-1:0] link;
	logic is_mem;
	logic lsu_done;
	logic [xlen-1:0] load_value;
	logic [xlen-1:0] u_imm;
	result_t res_next;

	assign in_ready = !busy; // stays low until result is taken
	assign is_mem = (op_class == cls_load) || (op_class == cls_store);
	assign u_imm = {iss_q.imm.u_form.upper, 12'b0};

	op_decode u_dec (.op(iss_q.op), .op_class(op_class), .alu_op(alu_op), .use_imm(use_imm),
		.mem_kind(mem_kind));

	alu u_alu (.alu_op(alu_op), .a(iss_q.rs1), .b(use_imm ? iss_q.imm.value : iss_q.rs2),
		.y(alu_y));

	branch_unit u_br (.op(iss_q.op), .rs1(iss_q.rs1), .rs2(iss_q.rs2), .pc(iss_q.pc),
		.imm(iss_q.imm), .taken(taken), .target(target), .link(link));

	lsu u_lsu (.clk(clk), .rst_n(rst_n), .start(exec_cycle && is_mem), .kind(mem_kind),
		.is_store(op_class == cls_store), .addr(alu_y), .store_data(iss_q.rs2),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_req_ready(mem_req_ready),
		.mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata), .done(lsu_done),
		.load_value(load_value));

	always_comb begin
		res_next.rd_we = !(op_class == cls_store || op_class == cls_branch);
		res_next.jump = taken && (op_class == cls_branch || op_class == cls_jal ||
			op_class == cls_jalr);
		res_next.jump_target = res_next.jump ? target : '0;
		case (op_class)
			cls_load: res_next.rd_value = load_value;
			cls_jal, cls_jalr: res_next.rd_value = link;
			cls_lui: res_next.rd_value = u_imm;
			cls_auipc: res_next.rd_value = iss_q.pc + u_imm;
			cls_alu: res_next.rd_value = alu_y;
			default: res_next.rd_value = '0; // no rd for store and branch
		endcase
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			iss_q <= in;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			exec_cycle <= 1'b0;
			out_valid <= 1'b0;
			out <= '0;
		end else begin
			exec_cycle <= in_valid && in_ready;
			if (in_valid && in_ready) begin
				busy <= 1'b1;
			end else if (out_valid && out_ready) begin
				busy <= 1'b0;
			end
			if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end
			if ((exec_cycle && !is_mem) || lsu_done) begin
				out_valid <= 1'b1; // one cycle for non-memory classes
				out <= res_next;
			end
		end
	end

endmodule

//--- exec_assertions.sv
`timescale 1ns/1ps
module exec_assertions import exec_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_ready,
	input issue_t in,
	input logic out_valid,
	input logic out_ready,
	input result_t out,
	input logic mem_req_valid,
	input mem_req_t mem_req,
	input logic mem_req_ready
);

	int fail_count = 0;
	logic fixed_issue;

	assign fixed_issue = in_valid && in_ready && !(|in.op[op_sw:op_lb]); // no loads or stores

	out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out))
		else begin
			$error("result changed while held by back-pressure");
			fail_count++;
		end

	ready_vs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		!(in_ready && out_valid))
		else begin
			$error("in_ready and out_valid high together");
			fail_count++;
		end

	req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
		else begin
			$error("memory request dropped or changed before acceptance");
			fail_count++;
		end

	// out_valid rises on the edge after the issue edge
	one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		$past(fixed_issue, 2) |-> out_valid && !$past(out_valid))
		else begin
			$error("result not valid one cycle after issue");
			fail_count++;
		end

endmodule

bind exec_unit exec_assertions u_assert (.*);

//--- tb_exec_unit.sv
`timescale 1ns/1ps
module tb_exec_unit import exec_pkg::*; ();

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic in_valid = 1'b0;
	logic in_ready;
	issue_t in_pkt = '0;
	logic out_valid;
	logic out_ready = 1'b0;
	result_t out_pkt;
	logic mem_req_valid;
	mem_req_t mem_req;
	logic mem_req_ready = 1'b0;
	logic mem_rsp_valid = 1'b0;
	logic [xlen-1:0] mem_rdata = '0;

	logic [31:0] mem [64];
	logic [31:0] model_mem [64];
	logic [31:0] stim_rng = 32'h34c8;
	logic [31:0] env_rng = 32'h34c8;
	logic [5:0] rsp_addr = '0;
	logic [1:0] rsp_wait = 2'd0;
	logic stall_en = 1'b0;
	int issued = 0;
	int checks = 0;
	int errors = 0;
	int cycle_count = 0;
	int mark_chk = 0;
	int mark_err = 0;

	exec_unit i_dut (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
		.in(in_pkt), .out_valid(out_valid), .out_ready(out_ready), .out(out_pkt),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_req_ready(mem_req_ready),
		.mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata));

	initial begin
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] rand32();
		stim_rng = xorshift(stim_rng);
		return stim_rng;
	endfunction

	function automatic logic [31:0] imm12(input logic [31:0] r);
		return {{20{r[11]}}, r[11:0]};
	endfunction

	function automatic logic [31:0] fill_word(input int i);
		return {8'(i), 8'(~i), 8'(i * 7), 8'(i ^ 8'ha5)};
	endfunction

	// offset inside the word, forced to the access size
	function automatic logic [31:0] lane_off(input int op, input logic [31:0] r);
		if (op == op_lw || op == op_sw)
			return 32'd0;
		if (op == op_lh || op == op_lhu || op == op_sh)
			return {30'b0, r[1], 1'b0};
		return {30'b0, r[1:0]};
	endfunction

	// expected result, also updates model memory for stores
	function automatic result_t model(input issue_t p);
		result_t r;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [31:0] w;
		logic [7:0] bv;
		logic [15:0] hv;
		r = '0;
		a = p.rs1;
		imm = p.imm.value;
		b = (|p.op[op_sltiu:op_addi]) ? imm : p.rs2;
		addr = a + imm;
		w = model_mem[addr[7:2]];
		bv = 8'(w >> {addr[1:0], 3'b000});
		hv = 16'(w >> {addr[1], 4'b0000});
		r.rd_we = !(|p.op[op_bgeu:op_sb]); // stores and branches write no rd
		case (1'b1)
			p.op[op_add], p.op[op_addi]: r.rd_value = a + b;
			p.op[op_sub]: r.rd_value = a - b;
			p.op[op_xor], p.op[op_xori]: r.rd_value = a ^ b;
			p.op[op_or], p.op[op_ori]: r.rd_value = a | b;
			p.op[op_and], p.op[op_andi]: r.rd_value = a & b;
			p.op[op_sll], p.op[op_slli]: r.rd_value = a << b[4:0];
			p.op[op_srl], p.op[op_srli]: r.rd_value = a >> b[4:0];
			p.op[op_sra], p.op[op_srai]: r.rd_value = $signed(a) >>> b[4:0];
			p.op[op_slt], p.op[op_slti]: r.rd_value = {31'b0, $signed(a) < $signed(b)};
			p.op[op_sltu], p.op[op_sltiu]: r.rd_value = {31'b0, a < b};
			p.op[op_lb]: r.rd_value = {{24{bv[7]}}, bv};
			p.op[op_lbu]: r.rd_value = {24'b0, bv};
			p.op[op_lh]: r.rd_value = {{16{hv[15]}}, hv};
			p.op[op_lhu]: r.rd_value = {16'b0, hv};
			p.op[op_lw]: r.rd_value = w;
			p.op[op_sb]: model_mem[addr[7:2]][{addr[1:0], 3'b000} +: 8] = p.rs2[7:0];
			p.op[op_sh]: model_mem[addr[7:2]][{addr[1], 4'b0000} +: 16] = p.rs2[15:0];
			p.op[op_sw]: model_mem[addr[7:2]] = p.rs2;
			p.op[op_beq]: r.jump = a == p.rs2;
			p.op[op_bne]: r.jump = a != p.rs2;
			p.op[op_blt]: r.jump = $signed(a) < $signed(p.rs2);
			p.op[op_bge]: r.jump = $signed(a) >= $signed(p.rs2);
			p.op[op_bltu]: r.jump = a < p.rs2;
			p.op[op_bgeu]: r.jump = a >= p.rs2;
			p.op[op_jal], p.op[op_jalr]: begin
				r.jump = 1'b1;
				r.rd_value = p.pc + 4;
			end
			p.op[op_lui]: r.rd_value = {imm[31:12], 12'b0};
			p.op[op_auipc]: r.rd_value = p.pc + {imm[31:12], 12'b0};
			default: r.rd_value = '0;
		endcase
		if (r.jump)
			r.jump_target = p.op[op_jalr] ? (a + imm) & ~32'd1 : p.pc + imm;
		return r;
	endfunction

	task automatic run_op(input string name, input int op, input logic [31:0] rs1,
		input logic [31:0] rs2, input logic [31:0] imm, input logic [31:0] pc);
		issue_t p;
		result_t exp;
		p = '0;
		p.op[op] = 1'b1;
		p.rs1 = rs1;
		p.rs2 = rs2;
		p.imm.value = imm;
		p.pc = pc;
		exp = model(p);
		issued++;
		in_valid <= 1'b1;
		in_pkt <= p;
		do @(posedge clk); while (!in_ready);
		in_valid <= 1'b0;
		do @(posedge clk); while (!(out_valid && out_ready));
		checks++;
		assert (out_pkt == exp) else begin
			$display("Fail %s: expected %h actual %h", name, exp, out_pkt);
			errors++;
		end
	endtask

	task automatic begin_count();
		mark_chk = checks;
		mark_err = errors;
	endtask

	task automatic report_test(input string test);
		$display("%s: %0d checks, %0d errors", test, checks - mark_chk, errors - mark_err);
	endtask

	// memory and result sink, stalls only in the back-pressure test
	always @(posedge clk) begin
		env_rng = xorshift(env_rng);
		mem_req_ready <= !stall_en || env_rng[1:0] != 2'b00;
		out_ready <= !stall_en || env_rng[3:2] != 2'b00;
		mem_rsp_valid <= 1'b0;
		if (!rst_n) begin
			for (int i = 0; i < 64; i++)
				mem[i] <= fill_word(i);
			rsp_wait <= 2'd0;
		end else begin
			if (rsp_wait == 2'd1) begin
				mem_rsp_valid <= 1'b1;
				mem_rdata <= mem[rsp_addr];
			end
			if (rsp_wait != 2'd0)
				rsp_wait <= rsp_wait - 2'd1;
			if (mem_req_valid && mem_req_ready && mem_req.we) begin
				mem[mem_req.addr[7:2]] <= mem_req.wdata;
			end else if (mem_req_valid && mem_req_ready) begin
				rsp_addr <= mem_req.addr[7:2];
				rsp_wait <= 2'd1 + {1'b0, env_rng[4]} + {1'b0, env_rng[5]}; // 1 to 3 cycles
			end
		end
	end

	initial begin
		while (cycle_count < 40 * issued + 100) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run went past %0d cycles without finishing", cycle_count);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] base;
		int op_sel;
		for (int i = 0; i < 64; i++)
			model_mem[i] = fill_word(i);
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		begin_count();
		for (int op = op_add; op <= op_sltiu; op++) begin
			repeat (3) begin
				r1 = rand32();
				r2 = rand32();
				run_op($sformatf("alu op %0d", op), op, r1, r2, imm12(rand32()), r1 ^ r2);
			end
		end
		report_test("alu ops");

		begin_count();
		for (int op = op_beq; op <= op_bgeu; op++) begin
			r1 = rand32();
			r2 = rand32();
			base = imm12(rand32()) & ~32'd1;
			run_op($sformatf("branch %0d equal", op), op, r1, r1, base, r2);
			run_op($sformatf("branch %0d neg pos", op), op, r1 | 32'h8000_0000,
				r2 & 32'h7fff_ffff, base, r2);
			run_op($sformatf("branch %0d pos neg", op), op, r1 & 32'h7fff_ffff,
				r2 | 32'h8000_0000, base, r2);
			run_op($sformatf("branch %0d random", op), op, r1, r2, base, r1 ^ r2);
		end
		report_test("branches");

		begin_count();
		for (int op = op_jal; op <= op_auipc; op++) begin
			repeat (4) begin
				r1 = rand32();
				r2 = rand32();
				run_op($sformatf("jump or upper op %0d", op), op, r1, r2, rand32(), r2 & ~32'd3);
			end
		end
		report_test("jal jalr lui auipc");

		begin_count();
		for (int op = op_lb; op <= op_lhu; op++) begin
			for (int off = 0; off < 4; off++) begin
				base = rand32() & 32'h0000_00fc;
				if (lane_off(op, 32'(off)) == 32'(off))
					run_op($sformatf("load op %0d offset %0d", op, off), op, base, 0, 32'(off), 0);
			end
		end
		report_test("loads");

		begin_count();
		for (int op = op_sb; op <= op_sw; op++) begin
			repeat (6) begin
				base = rand32() & 32'h0000_00fc;
				r1 = lane_off(op, rand32());
				run_op($sformatf("store op %0d", op), op, base, rand32(), r1, 0);
				run_op($sformatf("store op %0d readback", op), op_lw, base, 0, 0, 0);
			end
		end
		report_test("stores");

		begin_count();
		stall_en <= 1'b1;
		for (int n = 0; n < 60; n++) begin
			r1 = rand32();
			r2 = rand32();
			op_sel = int'(r1 % 32'd37);
			if (op_sel >= op_lb && op_sel <= op_sw)
				run_op($sformatf("mixed %0d op %0d", n, op_sel), op_sel, r2 & 32'h0000_00fc,
					rand32(), lane_off(op_sel, r1 >> 8), 0);
			else
				run_op($sformatf("mixed %0d op %0d", n, op_sel), op_sel, r2, rand32(),
					imm12(r1 >> 8), r1 & ~32'd3);
		end
		stall_en <= 1'b0;
		report_test("back-pressure");

		$display("total: %0d checks, %0d errors, %0d assertion failures", checks, errors,
			i_dut.u_assert.fail_count);
		if (errors == 0 && i_dut.u_assert.fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- flist.f
exec_pkg.sv
op_decode.sv
alu.sv
branch_unit.sv
lsu.sv
exec_unit.sv
exec_assertions.sv
tb_exec_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --assert --timing -j 0
TOP = tb_exec_unit
FLIST = flist.f
BUILD = obj_dir
SIM = $(BUILD)/V$(TOP)
LOG = sim.log
SIM_ARGS = +verilator+error+limit+1000
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(SIM)
	./$(SIM) $(SIM_ARGS) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
